//--- include/dcmp_defines.svh
// Width and depth defines for the bitstream decompressor
`ifndef DCMP_DEFINES_SVH
`define DCMP_DEFINES_SVH

// Stream word width, only 16 is supported
`define DCMP_DATA_WIDTH 16

// Window depth in words, sized for the longest header
`define DCMP_WINDOW_WORDS 3

// Header count field, four low bits plus eight high bits
`define DCMP_COUNT_WIDTH 12

// Run counter holds count / 2
`define DCMP_RUN_WIDTH 11

`endif

//--- logic/dcmp_pkg.sv
// Word type, window and run count types, block kind and state enums
`include "dcmp_defines.svh"

package dcmp_pkg;

	// One stream word
	typedef logic [`DCMP_DATA_WIDTH-1:0] word_t;

	// Valid or consumed window words, 0 to 3
	typedef logic [1:0] win_count_t;

	// Remaining output words of a block, minus one
	typedef logic [`DCMP_RUN_WIDTH-1:0] run_count_t;

	// Block kinds from header byte 0 bits 6:4
	typedef enum logic [2:0] {
		kind_zero = 3'b000,
		kind_fill = 3'b010,
		kind_raw  = 3'b101,
		kind_ones = 3'b111
	} dcmp_kind_e;

	// Block controller states
	typedef enum logic [1:0] {
		st_init   = 2'd0,
		st_header = 2'd1,
		st_fill   = 2'd2,
		st_raw    = 2'd3
	} dcmp_state_e;

endpackage

//--- logic/dcmp_word_window.sv
// Three-word input window with multi-word consume
`timescale 1ns/10ps
`include "dcmp_defines.svh"

module dcmp_word_window (
	input  logic                                      clk,
	input  logic                                      nreset,
	input  logic                                      win_clear,
	input  logic                                      sink_valid,
	input  dcmp_pkg::word_t                           sink_data,
	input  dcmp_pkg::win_count_t                      win_take,
	output logic                                      sink_ready,
	output dcmp_pkg::word_t [`DCMP_WINDOW_WORDS-1:0]  win_data,
	output dcmp_pkg::win_count_t                      win_count
);

	localparam dcmp_pkg::win_count_t full_count = dcmp_pkg::win_count_t'(`DCMP_WINDOW_WORDS);

	dcmp_pkg::word_t [`DCMP_WINDOW_WORDS-1:0] next_data;
	dcmp_pkg::win_count_t kept;
	dcmp_pkg::win_count_t count_next;
	logic sink_accept;

	// Room exists if not full, or if words leave in this same cycle
	assign sink_ready = !win_clear && ((win_count < full_count) || (win_take != '0));
	assign sink_accept = sink_valid && sink_ready;

	// Words that stay after this cycle's consume
	assign kept = win_count - win_take;
	assign count_next = kept + dcmp_pkg::win_count_t'(sink_accept);

	// Shift out consumed words, then append the new word behind the kept ones
	always_comb begin
		for (int i = 0; i < `DCMP_WINDOW_WORDS; i++) begin
			next_data[i] = win_data[i];
			if ((i + int'(win_take)) < `DCMP_WINDOW_WORDS) begin
				next_data[i] = win_data[i + int'(win_take)];
			end
			if (sink_accept && (i == int'(kept))) begin
				next_data[i] = sink_data;
			end
		end
	end

	// Payload words
	always_ff @(posedge clk) begin
		win_data <= next_data;
	end

	// Occupancy
	always_ff @(posedge clk) begin
		if (!nreset) begin
			win_count <= '0;
		end else if (win_clear) begin
			win_count <= '0;
		end else begin
			win_count <= count_next;
		end
	end

	// Controller must not consume words that have not arrived
	take_le_count_a: assert property (
		@(posedge clk) disable iff (!nreset)
		win_take <= win_count
	);

	// Occupancy after consume and append stays within the window depth
	count_in_range_a: assert property (
		@(posedge clk) disable iff (!nreset)
		(int'(win_count) - int'(win_take) + int'(sink_accept)) <= `DCMP_WINDOW_WORDS
	);

endmodule

//--- logic/dcmp_block_ctrl.sv
// Block controller with header decode, run counter, fill byte and state machine
`timescale 1ns/10ps
`include "dcmp_defines.svh"

module dcmp_block_ctrl (
	input  logic                                      clk,
	input  logic                                      nreset,
	input  logic                                      enable,
	input  dcmp_pkg::word_t [`DCMP_WINDOW_WORDS-1:0]  win_data,
	input  dcmp_pkg::win_count_t                      win_count,
	input  logic                                      gen_ready,
	output dcmp_pkg::win_count_t                      win_take,
	output logic                                      win_clear,
	output logic                                      gen_valid,
	output dcmp_pkg::word_t                           gen_data
);

	localparam int fill_copies = `DCMP_DATA_WIDTH / 8;

	dcmp_pkg::dcmp_state_e state;
	dcmp_pkg::dcmp_state_e state_next;
	dcmp_pkg::dcmp_kind_e hdr_kind;
	logic hdr_long;
	logic hdr_fill_like;
	logic [`DCMP_COUNT_WIDTH-1:0] hdr_count;
	dcmp_pkg::win_count_t hdr_len;
	logic hdr_ready;
	logic [7:0] fill_byte;
	logic [7:0] fill_next;
	dcmp_pkg::run_count_t run_cnt;
	logic run_done;
	logic gen_fire;

	// Header bytes sit one per word in the low half, byte 1 is the high count
	assign hdr_long = win_data[0][7];
	assign hdr_kind = dcmp_pkg::dcmp_kind_e'(win_data[0][6:4]);
	assign hdr_count = hdr_long ? {win_data[1][7:0], win_data[0][3:0]} :
		{8'h00, win_data[0][3:0]};

	// Kind decode, unknown kinds behave as a fill with the last fill byte
	always_comb begin
		case (hdr_kind)
			dcmp_pkg::kind_zero: begin
				hdr_fill_like = 1'b0;
				fill_next = 8'h00;
			end
			dcmp_pkg::kind_ones: begin
				hdr_fill_like = 1'b0;
				fill_next = 8'hFF;
			end
			dcmp_pkg::kind_raw: begin
				hdr_fill_like = 1'b0;
				fill_next = fill_byte;
			end
			dcmp_pkg::kind_fill: begin
				hdr_fill_like = 1'b1;
				// Fill byte is the last header word
				fill_next = hdr_long ? win_data[2][7:0] : win_data[1][7:0];
			end
			default: begin
				hdr_fill_like = 1'b1;
				fill_next = fill_byte;
			end
		endcase
	end

	// One word, plus one for a long count, plus one for a fill byte
	assign hdr_len = dcmp_pkg::win_count_t'(1) + dcmp_pkg::win_count_t'(hdr_long) +
		dcmp_pkg::win_count_t'(hdr_fill_like);

	// Whole header present in the window
	assign hdr_ready = (state == dcmp_pkg::st_header) && (win_count >= hdr_len);

	assign win_clear = (state == dcmp_pkg::st_init);
	assign run_done = (run_cnt == '0);
	assign gen_fire = gen_valid && gen_ready;

	// Output word and window consume
	always_comb begin
		gen_valid = 1'b0;
		win_take = '0;
		case (state)
			dcmp_pkg::st_header: begin
				if (hdr_ready) begin
					win_take = hdr_len;
				end
			end
			dcmp_pkg::st_fill: begin
				gen_valid = 1'b1;
			end
			dcmp_pkg::st_raw: begin
				gen_valid = (win_count != '0);
				if (gen_valid && gen_ready) begin
					win_take = dcmp_pkg::win_count_t'(1);
				end
			end
			default: begin
				gen_valid = 1'b0;
			end
		endcase
	end

	assign gen_data = (state == dcmp_pkg::st_raw) ? win_data[0] : {fill_copies{fill_byte}};

	// Next state
	always_comb begin
		state_next = state;
		if (!enable) begin
			state_next = dcmp_pkg::st_init;
		end else begin
			case (state)
				dcmp_pkg::st_init: begin
					state_next = dcmp_pkg::st_header;
				end
				dcmp_pkg::st_header: begin
					if (hdr_ready) begin
						if (hdr_kind == dcmp_pkg::kind_raw) begin
							state_next = dcmp_pkg::st_raw;
						end else begin
							state_next = dcmp_pkg::st_fill;
						end
					end
				end
				default: begin
					// Last word of the block goes out at count zero
					if (gen_fire && run_done) begin
						state_next = dcmp_pkg::st_header;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			state <= dcmp_pkg::st_init;
		end else begin
			state <= state_next;
		end
	end

	// Run counter and fill byte are loaded together with the header consume
	always_ff @(posedge clk) begin
		if (!nreset) begin
			run_cnt <= '0;
			fill_byte <= 8'h00;
		end else if (hdr_ready) begin
			run_cnt <= hdr_count[`DCMP_COUNT_WIDTH-1:1];
			fill_byte <= fill_next;
		end else if (gen_fire) begin
			run_cnt <= run_cnt - dcmp_pkg::run_count_t'(1);
		end
	end

	// No output before a header has been consumed
	no_gen_in_header_a: assert property (
		@(posedge clk) disable iff (!nreset)
		((state inside {dcmp_pkg::st_init, dcmp_pkg::st_header}) && !hdr_ready)
			|=> !gen_valid
	);

	// An offered word waits unchanged, raw words stay at the window head
	gen_hold_a: assert property (
		@(posedge clk) disable iff (!nreset || !enable)
		(gen_valid && !gen_ready) |=> (gen_valid && $stable(gen_data))
	);

endmodule

//--- logic/dcmp_out_stage.sv
// One-entry registered output stage
`timescale 1ns/10ps

module dcmp_out_stage (
	input  logic            clk,
	input  logic            nreset,
	input  logic            gen_valid,
	input  dcmp_pkg::word_t gen_data,
	input  logic            source_ready,
	output logic            gen_ready,
	output logic            out_valid,
	output dcmp_pkg::word_t out_data
);

	logic gen_fire;

	// Accept when empty or when the held word leaves this cycle
	assign gen_ready = !out_valid || source_ready;
	assign gen_fire = gen_valid && gen_ready;

	always_ff @(posedge clk) begin
		if (!nreset) begin
			out_valid <= 1'b0;
		end else if (gen_fire) begin
			out_valid <= 1'b1;
		end else if (source_ready) begin
			out_valid <= 1'b0;
		end
	end

	// Held word
	always_ff @(posedge clk) begin
		if (gen_fire) begin
			out_data <= gen_data;
		end
	end

	// Stalled word is neither lost nor changed
	out_hold_a: assert property (
		@(posedge clk) disable iff (!nreset)
		(out_valid && !source_ready) |=> (out_valid && $stable(out_data))
	);

endmodule

//--- logic/dcmp_top.sv
// Decompressor top with window, block controller, output stage and enable bypass
`timescale 1ns/10ps
`include "dcmp_defines.svh"

module dcmp_top (
	input  logic            clk,
	input  logic            nreset,
	input  logic            enable,
	input  logic            sink_valid,
	input  dcmp_pkg::word_t sink_data,
	output logic            sink_ready,
	output logic            source_valid,
	output dcmp_pkg::word_t source_data,
	input  logic            source_ready
);

	dcmp_pkg::word_t [`DCMP_WINDOW_WORDS-1:0] win_data;
	dcmp_pkg::win_count_t win_count;
	dcmp_pkg::win_count_t win_take;
	logic win_clear;
	logic win_sink_valid;
	logic win_sink_ready;
	logic gen_valid;
	dcmp_pkg::word_t gen_data;
	logic gen_ready;
	logic stage_ready;
	logic out_valid;
	dcmp_pkg::word_t out_data;

	// Window only sees the sink while decompressing
	assign win_sink_valid = enable && sink_valid;

	// Stage drains while bypassed so no stale word comes out later
	assign stage_ready = source_ready || !enable;

	dcmp_word_window window_i (
		.clk        (clk),
		.nreset     (nreset),
		.win_clear  (win_clear),
		.sink_valid (win_sink_valid),
		.sink_data  (sink_data),
		.win_take   (win_take),
		.sink_ready (win_sink_ready),
		.win_data   (win_data),
		.win_count  (win_count)
	);

	dcmp_block_ctrl ctrl_i (
		.clk       (clk),
		.nreset    (nreset),
		.enable    (enable),
		.win_data  (win_data),
		.win_count (win_count),
		.gen_ready (gen_ready),
		.win_take  (win_take),
		.win_clear (win_clear),
		.gen_valid (gen_valid),
		.gen_data  (gen_data)
	);

	dcmp_out_stage out_i (
		.clk          (clk),
		.nreset       (nreset),
		.gen_valid    (gen_valid),
		.gen_data     (gen_data),
		.source_ready (stage_ready),
		.gen_ready    (gen_ready),
		.out_valid    (out_valid),
		.out_data     (out_data)
	);

	// Bypass passes the stream straight through when enable is low
	assign source_valid = enable ? out_valid : sink_valid;
	assign source_data = enable ? out_data : sink_data;
	assign sink_ready = enable ? win_sink_ready : source_ready;

endmodule

//--- sim/dcmp_tb.sv
// Decompressor testbench with stream model, directed tests, compare tasks and watchdog
`timescale 1ns/10ps

module dcmp_tb;

	logic clk;
	logic nreset;
	logic enable;
	logic sink_valid;
	dcmp_pkg::word_t sink_data;
	logic sink_ready;
	logic source_valid;
	dcmp_pkg::word_t source_data;
	logic source_ready;

	// Words waiting for the sink, words expected on the source
	dcmp_pkg::word_t sink_q[$];
	dcmp_pkg::word_t exp_q[$];
	// Block kind for each first header word in sink_q, -1 for other words
	int sink_tag_q[$];

	logic [31:0] lcg_state;
	logic back_pressure;
	int total_words;
	int errors;
	int tests_run;
	int tests_failed;

	dcmp_top dut_i (
		.clk          (clk),
		.nreset       (nreset),
		.enable       (enable),
		.sink_valid   (sink_valid),
		.sink_data    (sink_data),
		.sink_ready   (sink_ready),
		.source_valid (source_valid),
		.source_data  (source_data),
		.source_ready (source_ready)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	// LCG step, the upper half has the better bits
	function automatic logic [15:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	function automatic int rand_below(input int limit);
		return int'(next_rand()) % limit;
	endfunction

	task automatic compare_word(input string name, input dcmp_pkg::word_t actual,
		input dcmp_pkg::word_t expected);
		if (actual !== expected) begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic compare_kind(input dcmp_pkg::dcmp_kind_e actual,
		input dcmp_pkg::dcmp_kind_e expected);
		if (actual !== expected) begin
			errors++;
			$display("mismatch at %0t: sink_data kind got %s expected %s", $time,
				actual.name(), expected.name());
		end
	endtask

	task automatic queue_sink(input dcmp_pkg::word_t w, input int kind_tag);
		sink_q.push_back(w);
		sink_tag_q.push_back(kind_tag);
	endtask

	// Header words go to the sink queue, decompressed words to the expected queue
	task automatic encode_block(input dcmp_pkg::dcmp_kind_e kind, input logic [11:0] count,
		input logic [7:0] fill, input logic force_long);
		logic is_long;
		dcmp_pkg::word_t w;
		int n;
		is_long = force_long || (count > 12'd15);
		// One header byte per word, in the low half
		queue_sink({8'h00, is_long, kind, count[3:0]}, int'(kind));
		if (is_long) begin
			queue_sink({8'h00, count[11:4]}, -1);
		end
		// Fill byte comes after the count bytes
		if (kind == dcmp_pkg::kind_fill) begin
			queue_sink({8'h00, fill}, -1);
		end
		n = int'(count[11:1]) + 1;
		for (int i = 0; i < n; i++) begin
			case (kind)
				dcmp_pkg::kind_zero: exp_q.push_back(16'h0000);
				dcmp_pkg::kind_ones: exp_q.push_back(16'hFFFF);
				dcmp_pkg::kind_fill: exp_q.push_back({fill, fill});
				default: begin
					w = next_rand();
					queue_sink(w, -1);
					exp_q.push_back(w);
				end
			endcase
		end
		total_words += n;
	endtask

	// Sample at the falling edge, act just after the rising edge
	initial begin : stream_model
		logic sink_fire;
		logic source_fire;
		dcmp_pkg::word_t sent;
		dcmp_pkg::word_t seen;
		int tag;
		forever begin
			@(negedge clk);
			sink_fire = sink_valid && sink_ready;
			source_fire = source_valid && source_ready;
			sent = sink_data;
			seen = source_data;
			@(posedge clk);
			#1;
			if (sink_fire) begin
				void'(sink_q.pop_front());
				tag = sink_tag_q.pop_front();
				// Block kind as it left on the sink
				if (tag >= 0) begin
					compare_kind(dcmp_pkg::dcmp_kind_e'(sent[6:4]),
						dcmp_pkg::dcmp_kind_e'(tag[2:0]));
				end
			end
			if (source_fire) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("source word %h at %0t came out with nothing expected", seen, $time);
				end else begin
					compare_word("source_data", seen, exp_q.pop_front());
				end
			end
			sink_valid = (sink_q.size() != 0);
			if (sink_valid) begin
				sink_data = sink_q[0];
			end
			source_ready = back_pressure ? (rand_below(4) != 0) : 1'b1;
		end
	end

	// Limit grows with every queued word
	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles <= (total_words * 40 + 1000)) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, %0d words still expected", cycles, exp_q.size());
		$display("Simulation FAILED");
		$finish;
	end

	task automatic wait_drain();
		while ((sink_q.size() != 0) || (exp_q.size() != 0)) begin
			@(posedge clk);
		end
		// Idle cycles to catch extra words
		repeat (6) @(posedge clk);
	endtask

	task automatic set_enable(input logic value);
		@(posedge clk);
		#1;
		enable = value;
	endtask

	task automatic report_test(input string name, input int err_before);
		tests_run++;
		if (errors != err_before) begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_before);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	task automatic short_runs_test();
		int err_before;
		err_before = errors;
		for (int c = 0; c < 16; c++) begin
			encode_block(dcmp_pkg::kind_zero, 12'(c), 8'h00, 1'b0);
			encode_block(dcmp_pkg::kind_ones, 12'(c), 8'h00, 1'b0);
			encode_block(dcmp_pkg::kind_fill, 12'(c), 8'(next_rand()), 1'b0);
		end
		wait_drain();
		report_test("short_runs", err_before);
	endtask

	task automatic long_runs_test();
		int err_before;
		err_before = errors;
		encode_block(dcmp_pkg::kind_zero, 12'd4095, 8'h00, 1'b0);
		encode_block(dcmp_pkg::kind_ones, 12'd300, 8'h00, 1'b0);
		encode_block(dcmp_pkg::kind_fill, 12'd777, 8'hA5, 1'b0);
		encode_block(dcmp_pkg::kind_fill, 12'd2, 8'h3C, 1'b1);
		encode_block(dcmp_pkg::kind_ones, 12'd0, 8'h00, 1'b1);
		encode_block(dcmp_pkg::kind_fill, 12'd16, 8'hC3, 1'b0);
		wait_drain();
		report_test("long_runs", err_before);
	endtask

	task automatic raw_copy_test();
		int err_before;
		err_before = errors;
		encode_block(dcmp_pkg::kind_raw, 12'd0, 8'h00, 1'b0);
		encode_block(dcmp_pkg::kind_raw, 12'd1, 8'h00, 1'b0);
		encode_block(dcmp_pkg::kind_raw, 12'd6, 8'h00, 1'b0);
		encode_block(dcmp_pkg::kind_raw, 12'd15, 8'h00, 1'b0);
		encode_block(dcmp_pkg::kind_raw, 12'd3, 8'h00, 1'b1);
		encode_block(dcmp_pkg::kind_raw, 12'd64, 8'h00, 1'b0);
		encode_block(dcmp_pkg::kind_raw, 12'd513, 8'h00, 1'b0);
		wait_drain();
		report_test("raw_copy", err_before);
	endtask

	task automatic random_mix_test();
		int err_before;
		dcmp_pkg::dcmp_kind_e kind;
		logic [11:0] count;
		err_before = errors;
		back_pressure = 1'b1;
		for (int b = 0; b < 40; b++) begin
			case (rand_below(4))
				0: kind = dcmp_pkg::kind_zero;
				1: kind = dcmp_pkg::kind_fill;
				2: kind = dcmp_pkg::kind_raw;
				default: kind = dcmp_pkg::kind_ones;
			endcase
			// Mostly short blocks, now and then a long one
			count = (rand_below(4) == 0) ? 12'(rand_below(600)) : 12'(rand_below(16));
			encode_block(kind, count, 8'(next_rand()), rand_below(3) == 0);
		end
		wait_drain();
		back_pressure = 1'b0;
		report_test("random_mix", err_before);
	endtask

	task automatic bypass_test();
		int err_before;
		dcmp_pkg::word_t w;
		err_before = errors;
		set_enable(1'b0);
		back_pressure = 1'b1;
		for (int i = 0; i < 20; i++) begin
			w = next_rand();
			queue_sink(w, -1);
			exp_q.push_back(w);
			total_words++;
		end
		wait_drain();
		back_pressure = 1'b0;
		// Fresh blocks once the decompressor is back
		set_enable(1'b1);
		encode_block(dcmp_pkg::kind_fill, 12'd9, 8'h5A, 1'b0);
		encode_block(dcmp_pkg::kind_raw, 12'd5, 8'h00, 1'b0);
		encode_block(dcmp_pkg::kind_ones, 12'd40, 8'h00, 1'b0);
		wait_drain();
		report_test("bypass", err_before);
	endtask

	initial begin
		lcg_state = 32'h308d;
		back_pressure = 1'b0;
		total_words = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		nreset = 1'b0;
		enable = 1'b1;
		sink_valid = 1'b0;
		sink_data = '0;
		source_ready = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		nreset = 1'b1;

		short_runs_test();
		long_runs_test();
		raw_copy_test();
		random_mix_test();
		bypass_test();

		$display("tests run %0d, tests failed %0d, errors %0d, words %0d", tests_run,
			tests_failed, errors, total_words);
		if ((errors == 0) && (tests_failed == 0)) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- list.f
+incdir+include
logic/dcmp_pkg.sv
logic/dcmp_word_window.sv
logic/dcmp_block_ctrl.sv
logic/dcmp_out_stage.sv
logic/dcmp_top.sv
sim/dcmp_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the decompressor testbench with Verilator, runs it and checks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module dcmp_tb -f list.f \
	&& ./obj_dir/Vdcmp_tb | tee /dev/stderr | grep -qx "Simulation PASSED" \
	&& echo "run_sim: pass line found" \
	|| { echo "run_sim: build error or pass line missing"; exit 1; }
